// File: efpga_lint_test.f
efpga_lint_pkg.sv
lint_decode.sv
ctrl_regs.sv
ram_port.sv
read_mux.sv
efpga_test_top.sv
efpga_lint_checker.sv
tb_efpga_test.sv

// File: tb_efpga_test.sv
// ##########################################################################
// testbench for the lint bus test block
// applies a table of bus accesses in order against a 1-cycle operand ram
// model and a memory-bus responder
// ##########################################################################

module tb_efpga_test
  import efpga_lint_pkg::*;
;

  typedef enum {k_none, k_math, k_port, k_ram, k_ramctl, k_tcdm, k_clken} check_kind_t;

  typedef struct {
    string       name;
    logic        write;
    bus_addr_t   addr;
    word_t       wdata;
    be_t         be;
    word_t       exp;   // read data, or the value that kind checks
    check_kind_t kind;
  } test_t;

  logic       CLK = 1'b0;
  logic       rst, lint_req, lint_wen, lint_gnt, lint_valid, math_clken, ram_we;
  logic       tcdm_req, tcdm_gnt, tcdm_fmo, tcdm_valid;
  bus_addr_t  lint_addr;
  word_t      lint_wdata, lint_rdata, math_result, gpio_out, gpio_oe, gpio_in;
  word_t      ram_wdata, ram_rdata, tcdm_rdata;
  be_t        lint_be;
  math_ctrl_t math_ctrl;
  ram_ctrl_t  ram_ctrl;
  ram_addr_t  ram_raddr, ram_waddr;
  tcdm_req_t  tcdm;

  test_t       tests[$];
  logic        tests_ready = 1'b0;
  int          errors = 0;
  int          clken_count = 0;
  int          clken_before;
  logic [15:0] lfsr_state = 16'd47394;
  word_t       ram_mem [4096];
  word_t       tcdm_mem [tcdm_addr_t];

  efpga_test_top i_efpga_test_top (.*);

  always #2 CLK = ~CLK;

  always @(posedge CLK) begin
    if (math_clken === 1'b1) clken_count++;
  end

  function automatic logic lfsr_next_bit();
    logic out;
    out = lfsr_state[0];
    lfsr_state = {1'b0, lfsr_state[15:1]} ^ (out ? 16'hB400 : 16'h0000);
    return out;
  endfunction

  function automatic word_t lfsr_take(input int n);
    word_t v;
    v = '0;
    for (int b = 0; b < n; b++) v = {v[30:0], lfsr_next_bit()};
    return v;
  endfunction

  // ram model samples the address mid-cycle and drives data after the edge
  initial begin : ram_model
    word_t     rd, wd;
    logic      we;
    ram_addr_t wa;
    for (int a = 0; a < 4096; a++) ram_mem[a] = {a[11:0], ~a[11:0], a[7:0]};
    ram_rdata = '0;
    forever begin
      @(negedge CLK);
      rd = ram_mem[ram_raddr];
      we = ram_we;
      wa = ram_waddr;
      wd = ram_wdata;
      @(posedge CLK);
      #1;
      if (we === 1'b1) ram_mem[wa] = wd;
      ram_rdata = rd;
    end
  end

  // memory-bus responder grants after a random delay and returns valid two cycles later
  initial begin : tcdm_responder
    int    gnt_delay;
    word_t rdata;
    tcdm_gnt   = 1'b0;
    tcdm_fmo   = 1'b0;
    tcdm_valid = 1'b0;
    tcdm_rdata = '0;
    forever begin
      @(posedge CLK);
      #1;
      if (tcdm_req === 1'b1) begin
        gnt_delay = int'(lfsr_take(2));
        repeat (gnt_delay) @(posedge CLK);
        if (gnt_delay != 0) #1;
        tcdm_gnt = 1'b1;
        rdata = '0; // writes return no data
        if (!tcdm.wen) tcdm_mem[tcdm.addr] = tcdm.wdata;
        else if (tcdm_mem.exists(tcdm.addr)) rdata = tcdm_mem[tcdm.addr];
        @(posedge CLK);
        #1;
        tcdm_gnt = 1'b0;
        @(posedge CLK);
        #1;
        tcdm_valid = 1'b1;
        tcdm_rdata = rdata;
        @(posedge CLK);
        #1;
        tcdm_valid = 1'b0;
      end
    end
  end

  task automatic check_word(input string name, input word_t exp, input word_t act);
    if (act !== exp) begin
      errors++;
      $display("FAILED %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  // fields against their bit positions in the raw word
  task automatic check_math_ctrl(input string name, input word_t exp, input math_ctrl_t act);
    if (act.outsel !== exp[5:0] || act.tc !== exp[6] || act.mode !== exp[13:12] ||
        act.osel !== exp[14] || act.csel !== exp[15] || act.rnd !== exp[16] ||
        act.clr !== exp[17] || act.sat !== exp[18] || act.math_reset !== exp[31]) begin
      errors++;
      $display("FAILED %s: expected %h, actual %h", name, exp, word_t'(act));
    end
  endtask

  // mode and select fields against their bit positions in the raw word
  task automatic check_ram_ctrl(input string name, input word_t exp, input ram_ctrl_t act);
    if (act.rmode !== exp[1:0] || act.wmode !== exp[3:2] || act.wdsel !== exp[12]) begin
      errors++;
      $display("FAILED %s: expected %h, actual %h", name, exp, word_t'(act));
    end
  endtask

  task automatic add_test(input string name, input logic write, input bus_addr_t addr,
                          input word_t wdata, input be_t be, input word_t exp,
                          input check_kind_t kind);
    test_t t;
    t = '{name, write, addr, wdata, be, exp, kind};
    tests.push_back(t);
  endtask

  // hold the request until grant, then wait for valid
  task automatic bus_access(input test_t t);
    @(posedge CLK);
    #1;
    lint_req   = 1'b1;
    lint_wen   = !t.write;
    lint_addr  = t.addr;
    lint_wdata = t.wdata;
    lint_be    = t.be;
    @(negedge CLK);
    while (!lint_gnt) @(negedge CLK);
    @(posedge CLK);
    #1;
    lint_req = 1'b0;
    @(negedge CLK);
    while (!lint_valid) @(negedge CLK);
  endtask

  task automatic tcdm_transfer_check(input test_t t);
    logic held;
    held = 1'b1;
    while (tcdm_gnt !== 1'b1) begin
      if (tcdm_req !== 1'b1) held = 1'b0;
      @(negedge CLK);
    end
    if (!held || tcdm_req !== 1'b1) begin
      errors++;
      $display("%s: memory-bus request dropped before its grant", t.name);
    end
    check_word({t.name, " wdata"}, t.wdata, tcdm.wdata);
    check_word({t.name, " request"}, t.exp, {tcdm.wen, 7'b0, tcdm.be, tcdm.addr});
    @(negedge CLK);
    if (tcdm_req !== 1'b0) begin
      errors++;
      $display("%s: memory-bus request still high after its grant", t.name);
    end
    while (!tcdm_valid) @(negedge CLK);
    @(posedge CLK); // result captured here
  endtask

  task automatic run_check(input test_t t);
    case (t.kind)
      k_none:  if (!t.write) check_word(t.name, t.exp, lint_rdata);
      k_math:  check_math_ctrl(t.name, t.exp, math_ctrl);
      k_port:  check_word(t.name, t.exp, (t.addr == reg_gpio_out) ? gpio_out : gpio_oe);
      k_ram: begin
        @(negedge CLK);
        check_word(t.name, t.exp, ram_mem[t.addr[11:0]]);
      end
      k_ramctl: check_ram_ctrl(t.name, t.exp, ram_ctrl);
      k_tcdm:  tcdm_transfer_check(t);
      k_clken: begin
        repeat (3) @(negedge CLK);
        check_word(t.name, t.exp, word_t'(clken_count - clken_before));
      end
      default: ;
    endcase
  endtask

  initial begin : watchdog
    wait (tests_ready);
    #(tests.size() * 40 * 4); // 40 clock periods per table entry
    $display("timeout: the test table did not complete in time");
    $display("Simulation failed");
    $finish;
  end

  initial begin : main
    int    passed;
    int    err_before;
    int    total;
    string verdict;
    rst        = 1'b1;
    lint_req   = 1'b0;
    lint_wen   = 1'b1;
    lint_addr  = '0;
    lint_wdata = '0;
    lint_be    = '0;
    gpio_in    = 32'h1357_9BDF;
    math_result = lfsr_take(32);
    passed     = 0;

    add_test("math ctrl full", 1, reg_math_ctrl, 32'h8005_704B, 4'hF, 32'h8005_704B, k_math);
    add_test("math ctrl bytes", 1, reg_math_ctrl, 32'h1234_5678, 4'h5, 32'h8034_7078, k_math);
    add_test("math ctrl read", 0, reg_math_ctrl, 0, 4'hF, 32'h8034_7078, k_none);
    add_test("gpio out write", 1, reg_gpio_out, 32'hA5A5_0F0F, 4'hF, 32'hA5A5_0F0F, k_port);
    add_test("gpio oe write", 1, reg_gpio_oe, 32'h0000_FFFF, 4'hF, 32'h0000_FFFF, k_port);
    add_test("gpio out read", 0, reg_gpio_out, 0, 4'hF, 32'hA5A5_0F0F, k_none);
    add_test("gpio oe read", 0, reg_gpio_oe, 0, 4'hF, 32'h0000_FFFF, k_none);
    add_test("gpio in read", 0, reg_gpio_in, 0, 4'hF, 32'h1357_9BDF, k_none);
    add_test("id read", 0, reg_id, 0, 4'hF, 32'hCA11_EF3A, k_none);
    add_test("unmapped read", 0, 20'h00070, 0, 4'hF, 32'h0, k_none);
    add_test("ram ctrl wr word", 1, reg_ram_ctrl, 32'h0, 4'hF, 32'h0, k_ramctl);
    add_test("ram wr word", 1, 20'h01100, 32'h8765_4321, 4'hF, 32'h8765_4321, k_ram);
    add_test("ram ctrl wr half", 1, reg_ram_ctrl, 32'h4, 4'hF, 32'h4, k_ramctl);
    add_test("ram wr half high", 1, 20'h01102, 32'hCAFE_1234, 4'hF, 32'h0000_CAFE, k_ram);
    add_test("ram wr half low", 1, 20'h01104, 32'h5678_9ABC, 4'hF, 32'h5678_9ABC, k_ram);
    add_test("ram ctrl wr byte", 1, reg_ram_ctrl, 32'h8, 4'hF, 32'h8, k_ramctl);
    add_test("ram wr byte 3", 1, 20'h01107, 32'h1122_3344, 4'hF, 32'h0000_0011, k_ram);
    add_test("ram wr byte 1", 1, 20'h01105, 32'h1122_3344, 4'hF, 32'h0000_0033, k_ram);
    add_test("ram ctrl rd word", 1, reg_ram_ctrl, 32'h0, 4'hF, 32'h0, k_ramctl);
    add_test("ram rd word", 0, 20'h01100, 0, 4'hF, 32'h8765_4321, k_none);
    add_test("ram ctrl rd half", 1, reg_ram_ctrl, 32'h1, 4'hF, 32'h1, k_ramctl);
    add_test("ram rd half high", 0, 20'h01102, 0, 4'hF, 32'hCAFE_0000, k_none);
    add_test("ram rd half low", 0, 20'h01104, 0, 4'hF, 32'h5678_9ABC, k_none);
    add_test("ram ctrl rd byte", 1, reg_ram_ctrl, 32'h1002, 4'hF, 32'h1002, k_ramctl);
    add_test("ram rd byte 3", 0, 20'h01107, 0, 4'hF, 32'h1100_0000, k_none);
    add_test("ram rd byte 1", 0, 20'h01105, 0, 4'hF, 32'h0000_3300, k_none);
    add_test("ram ctrl read", 0, reg_ram_ctrl, 0, 4'hF, 32'h1002, k_none);
    add_test("tcdm cfg write", 1, reg_tcdm_cfg, 32'h00C0_ABCD, 4'hF, 0, k_none);
    add_test("tcdm cfg read", 0, reg_tcdm_cfg, 0, 4'hF, 32'h00C0_ABCD, k_none);
    add_test("tcdm data write", 1, reg_tcdm_data, 32'h2468_ACE0, 4'hF, 32'h0030_ABCD, k_tcdm);
    add_test("tcdm cfg read mode", 1, reg_tcdm_cfg, 32'h80C0_ABCD, 4'hF, 0, k_none);
    add_test("tcdm cfg read back", 0, reg_tcdm_cfg, 0, 4'hF, 32'h80C0_ABCD, k_none);
    add_test("tcdm read launch", 1, reg_tcdm_data, 32'h0, 4'hF, 32'h8030_ABCD, k_tcdm);
    add_test("tcdm result read", 0, reg_tcdm_data, 0, 4'hF, 32'h2468_ACE0, k_none);
    add_test("math clken pulse", 1, reg_math_clken, 32'h0, 4'hF, 32'h1, k_clken);
    add_test("math result read", 0, reg_math_result, 0, 4'hF, math_result, k_none);
    tests_ready = 1'b1;

    repeat (2) @(posedge CLK);
    #1;
    rst = 1'b0;
    @(negedge CLK);
    check_word("read data after reset", '1, lint_rdata);

    foreach (tests[i]) begin
      err_before   = errors;
      clken_before = clken_count;
      bus_access(tests[i]);
      run_check(tests[i]);
      verdict = (errors == err_before) ? "pass" : "fail";
      if (errors == err_before) passed++;
      $display("test %0d %s: %s", i, tests[i].name, verdict);
    end

    total = errors + i_efpga_test_top.i_lint_decode.i_lint_checker.fails;
    $display("tests %0d, passed %0d, failed %0d, check errors %0d",
             tests.size(), passed, tests.size() - passed, total);
    if (total == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: efpga_lint_checker.sv
// ##########################################################################
// concurrent checks on the lint bus handshake, bound into lint_decode
// ##########################################################################

module efpga_lint_checker (
  input logic CLK,
  input logic rst,
  input logic lint_gnt,
  input logic lint_valid,
  input logic exec_wr
);

  int fails = 0; // failed assertion count

  a_gnt_single: assert property (@(posedge CLK) disable iff (rst) lint_gnt |=> !lint_gnt)
  else begin
    fails++;
    $error("lint grant high for two cycles in a row");
  end

  a_valid_after_gnt: assert property (@(posedge CLK) disable iff (rst)
    lint_valid == $past(lint_gnt))
  else begin
    fails++;
    $error("lint valid does not follow grant by one cycle");
  end

  a_exec_with_gnt: assert property (@(posedge CLK) disable iff (rst) exec_wr |-> lint_gnt)
  else begin
    fails++;
    $error("write strobe without grant");
  end

  // handshake outputs come out of reset low
  a_reset_idle: assert property (@(posedge CLK) $past(rst) |-> !lint_gnt && !lint_valid)
  else begin
    fails++;
    $error("grant or valid high right after reset");
  end

endmodule

bind lint_decode efpga_lint_checker i_lint_checker (
  .CLK(CLK), .rst(rst), .lint_gnt(lint_gnt), .lint_valid(lint_valid), .exec_wr(exec_wr)
);

// File: efpga_test_top.sv
// ##########################################################################
// top of the lint bus test block: sequencer, control registers, ram port
// and read stage wired to the math, gpio, ram and memory-bus pins
// ##########################################################################

module efpga_test_top
  import efpga_lint_pkg::*;
(
  input  logic       CLK,
  input  logic       rst,
  // host lint bus
  input  logic       lint_req,
  input  logic       lint_wen,
  input  bus_addr_t  lint_addr,
  input  word_t      lint_wdata,
  input  be_t        lint_be,
  output logic       lint_gnt,
  output logic       lint_valid,
  output word_t      lint_rdata,
  // math block
  output math_ctrl_t math_ctrl,
  output logic       math_clken,
  input  word_t      math_result,
  // gpio
  output word_t      gpio_out,
  output word_t      gpio_oe,
  input  word_t      gpio_in,
  // operand ram
  output ram_addr_t  ram_raddr,
  output ram_addr_t  ram_waddr,
  output word_t      ram_wdata,
  output logic       ram_we,
  output ram_ctrl_t  ram_ctrl,
  input  word_t      ram_rdata,
  // memory bus
  output tcdm_req_t  tcdm,
  output logic       tcdm_req,
  input  logic       tcdm_gnt,
  input  logic       tcdm_fmo,
  input  logic       tcdm_valid,
  input  word_t      tcdm_rdata
);

  access_t access;
  logic    exec_wr;
  logic    read_sel;
  word_t   tcdm_result;

  lint_decode i_lint_decode (
    .CLK(CLK), .rst(rst),
    .lint_req(lint_req), .lint_wen(lint_wen), .lint_addr(lint_addr),
    .lint_wdata(lint_wdata), .lint_be(lint_be),
    .lint_gnt(lint_gnt), .lint_valid(lint_valid),
    .access(access), .exec_wr(exec_wr), .read_sel(read_sel)
  );

  ctrl_regs i_ctrl_regs (
    .CLK(CLK), .rst(rst), .access(access), .exec_wr(exec_wr),
    .tcdm_gnt(tcdm_gnt), .tcdm_fmo(tcdm_fmo), .tcdm_valid(tcdm_valid),
    .tcdm_rdata(tcdm_rdata), .math_ctrl(math_ctrl), .math_clken(math_clken),
    .ram_ctrl(ram_ctrl), .gpio_out(gpio_out), .gpio_oe(gpio_oe),
    .tcdm(tcdm), .tcdm_req(tcdm_req), .tcdm_result(tcdm_result)
  );

  ram_port i_ram_port (
    .CLK(CLK), .rst(rst), .access(access), .exec_wr(exec_wr),
    .read_sel(read_sel), .ram_ctrl(ram_ctrl),
    .ram_raddr(ram_raddr), .ram_waddr(ram_waddr),
    .ram_wdata(ram_wdata), .ram_we(ram_we)
  );

  read_mux i_read_mux (
    .CLK(CLK), .rst(rst), .access(access), .read_sel(read_sel),
    .ram_ctrl(ram_ctrl), .ram_rdata(ram_rdata), .math_ctrl(math_ctrl),
    .gpio_out(gpio_out), .gpio_oe(gpio_oe), .gpio_in(gpio_in),
    .tcdm(tcdm), .tcdm_result(tcdm_result), .math_result(math_result),
    .lint_rdata(lint_rdata)
  );

endmodule

// File: read_mux.sv
// ##########################################################################
// read result stage: picks a register in st_read or the aligned ram word
// in st_read_wait and holds it on lint_rdata through grant and valid
// ##########################################################################

module read_mux
  import efpga_lint_pkg::*;
(
  input  logic       CLK,
  input  logic       rst,
  input  access_t    access,
  input  logic       read_sel,
  input  ram_ctrl_t  ram_ctrl,
  input  word_t      ram_rdata,
  input  math_ctrl_t math_ctrl,
  input  word_t      gpio_out,
  input  word_t      gpio_oe,
  input  word_t      gpio_in,
  input  tcdm_req_t  tcdm,
  input  word_t      tcdm_result,
  input  word_t      math_result,
  output word_t      lint_rdata
);

  logic  rd_wait; // matches st_read_wait
  word_t reg_value;
  word_t ram_aligned;

  always_comb begin
    case (access.offset)
      reg_tcdm_cfg:    reg_value = {tcdm.wen, 7'b0, ~tcdm.be, tcdm.addr};
      reg_math_ctrl:   reg_value = word_t'(math_ctrl);
      reg_ram_ctrl:    reg_value = word_t'(ram_ctrl);
      reg_gpio_out:    reg_value = gpio_out;
      reg_gpio_oe:     reg_value = gpio_oe;
      reg_gpio_in:     reg_value = gpio_in;
      reg_tcdm_data:   reg_value = tcdm_result;
      reg_math_result: reg_value = math_result;
      reg_id:          reg_value = id_word;
      default:         reg_value = '0; // unmapped
    endcase
  end

  always_comb begin
    case (ram_ctrl.rmode)
      wm_word, wm_word3: ram_aligned = ram_rdata;
      wm_half: ram_aligned = access.byte_ofs[1] ? {ram_rdata[15:0], 16'b0} : ram_rdata;
      wm_byte: ram_aligned = ram_rdata << (8 * access.byte_ofs);
    endcase
  end

  always_ff @(posedge CLK) begin
    if (rst) begin
      rd_wait    <= 1'b0;
      lint_rdata <= '1;
    end else begin
      rd_wait <= read_sel;
      if (read_sel && !access.is_ram) begin
        lint_rdata <= reg_value;
      end else if (rd_wait && access.is_ram) begin
        lint_rdata <= ram_aligned;
      end
    end
  end

endmodule

// File: ram_port.sv
// ##########################################################################
// operand ram port: write packing by the wmode field and the read address
// hold; the ram is assumed to return data one cycle after the address
// ##########################################################################

module ram_port
  import efpga_lint_pkg::*;
(
  input  logic      CLK,
  input  logic      rst,
  input  access_t   access,
  input  logic      exec_wr,
  input  logic      read_sel,
  input  ram_ctrl_t ram_ctrl,
  output ram_addr_t ram_raddr,
  output ram_addr_t ram_waddr,
  output word_t     ram_wdata,
  output logic      ram_we
);

  ram_addr_t raddr_q;
  logic      ram_rd;
  logic      ram_wr;
  word_t     packed_wdata;

  assign ram_rd = read_sel && access.is_ram;
  assign ram_wr = exec_wr && access.is_ram;

  // address goes out in st_read, data comes back in st_read_wait
  assign ram_raddr = ram_rd ? access.ram_addr : raddr_q;

  always_comb begin
    case (ram_ctrl.wmode)
      wm_word, wm_word3: packed_wdata = access.wdata;
      wm_half: begin
        packed_wdata = access.byte_ofs[1] ? {16'b0, access.wdata[31:16]} : access.wdata;
      end
      wm_byte: packed_wdata = {24'b0, access.wdata[8*access.byte_ofs +: 8]};
    endcase
  end

  always_ff @(posedge CLK) begin
    if (rst) begin
      raddr_q <= '0;
      ram_we  <= 1'b0;
    end else begin
      ram_we <= ram_wr; // one cycle per write
      if (ram_rd) begin
        raddr_q <= access.ram_addr; // held between reads
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (ram_wr) begin
      ram_waddr <= access.ram_addr;
      ram_wdata <= packed_wdata;
    end
  end

endmodule

// File: ctrl_regs.sv
// ##########################################################################
// control registers: executes lint register writes and holds the math,
// ram, gpio and memory-bus port state, including the request handshake
// ##########################################################################

module ctrl_regs
  import efpga_lint_pkg::*;
(
  input  logic       CLK,
  input  logic       rst,
  input  access_t    access,
  input  logic       exec_wr,
  input  logic       tcdm_gnt,
  input  logic       tcdm_fmo,
  input  logic       tcdm_valid,
  input  word_t      tcdm_rdata,
  output math_ctrl_t math_ctrl,
  output logic       math_clken,
  output ram_ctrl_t  ram_ctrl,
  output word_t      gpio_out,
  output word_t      gpio_oe,
  output tcdm_req_t  tcdm,
  output logic       tcdm_req,
  output word_t      tcdm_result
);

  word_t math_word; // raw words, fields decoded through the structs
  word_t ram_word;

  assign math_ctrl = math_ctrl_t'(math_word);
  assign ram_ctrl  = ram_ctrl_t'(ram_word);

  always_ff @(posedge CLK) begin
    if (rst) begin
      math_word   <= '0;
      ram_word    <= '0;
      math_clken  <= 1'b0;
      gpio_out    <= '0;
      gpio_oe     <= '0;
      tcdm        <= '0;
      tcdm_req    <= 1'b0;
      tcdm_result <= '0;
    end else begin
      math_clken <= 1'b0;

      // request stays up until the port takes it
      if (tcdm_gnt && !tcdm_fmo) begin
        tcdm_req <= 1'b0;
      end
      if (tcdm_valid) begin
        tcdm_result <= tcdm_rdata; // latency set by the memory bus
      end

      // ram window never matches a register offset
      if (exec_wr) begin
        case (access.offset)
          reg_tcdm_cfg: begin
            tcdm.addr <= access.wdata[19:0];
            tcdm.be   <= ~access.wdata[23:20]; // stored inverted
            tcdm.wen  <= access.wdata[31];
          end
          reg_math_ctrl: begin
            for (int i = 0; i < 4; i++) begin
              if (access.be[i]) begin
                math_word[8*i +: 8] <= access.wdata[8*i +: 8];
              end
            end
          end
          reg_ram_ctrl:   ram_word   <= access.wdata;
          reg_math_clken: math_clken <= 1'b1; // single pulse
          reg_gpio_out:   gpio_out   <= access.wdata;
          reg_gpio_oe:    gpio_oe    <= access.wdata;
          reg_tcdm_data: begin
            tcdm.wdata <= access.wdata;
            tcdm_req   <= 1'b1; // launch, wins over the clear above
          end
          default: ;
        endcase
      end
    end
  end

endmodule

// File: lint_decode.sv
// ##########################################################################
// lint bus sequencer: accepts host requests, latches the access record
// and paces grant, valid and the execute strobes for the other blocks
// ##########################################################################

module lint_decode
  import efpga_lint_pkg::*;
(
  input  logic      CLK,
  input  logic      rst,
  input  logic      lint_req,
  input  logic      lint_wen,
  input  bus_addr_t lint_addr,
  input  word_t     lint_wdata,
  input  be_t       lint_be,
  output logic      lint_gnt,
  output logic      lint_valid,
  output access_t   access,
  output logic      exec_wr,
  output logic      read_sel
);

  lint_state_t state;
  logic        accept;

  // gnt low here keeps the held request from being taken twice
  assign accept = (state == st_idle) && lint_req && !lint_gnt;

  assign exec_wr  = (state == st_write) && access.is_write; // one cycle, with gnt
  assign read_sel = (state == st_read);                     // first cycle of a read

  always_ff @(posedge CLK) begin
    if (rst) begin
      state      <= st_idle;
      lint_gnt   <= 1'b0;
      lint_valid <= 1'b0;
    end else begin
      lint_valid <= lint_gnt; // valid trails grant by a cycle
      lint_gnt   <= 1'b0;
      case (state)
        st_idle: begin
          if (accept) begin
            if (!lint_wen) begin
              lint_gnt <= 1'b1;
              state    <= st_write;
            end else begin
              state <= st_read;
            end
          end
        end
        st_write: state <= st_idle;
        st_read: state <= st_read_wait;
        st_read_wait: begin
          lint_gnt <= 1'b1; // read data is in place by now
          state    <= st_idle;
        end
        default: state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if (accept) begin
      access.is_ram   <= (lint_addr[19:12] == ram_page);
      access.is_write <= !lint_wen;
      access.offset   <= lint_addr;
      access.ram_addr <= lint_addr[11:0];
      access.byte_ofs <= lint_addr[1:0];
      access.wdata    <= lint_wdata;
      access.be       <= lint_be;
    end
  end

endmodule

// File: efpga_lint_pkg.sv
// ##########################################################################
// shared types, register map and constants for the lint bus test block
// imported by wildcard into every module of the design
// ##########################################################################

package efpga_lint_pkg;

  typedef logic [31:0] word_t;       // bus and register data
  typedef logic [3:0]  be_t;         // byte enables
  typedef logic [19:0] bus_addr_t;   // lint bus address
  typedef logic [11:0] ram_addr_t;   // operand ram word address
  typedef logic [19:0] tcdm_addr_t;  // memory-bus address
  typedef logic [1:0]  width_mode_t; // ram access width

  // ram width modes, both 0 and 3 are full word
  localparam width_mode_t wm_word  = 2'd0;
  localparam width_mode_t wm_half  = 2'd1;
  localparam width_mode_t wm_byte  = 2'd2;
  localparam width_mode_t wm_word3 = 2'd3;

  localparam bus_addr_t reg_tcdm_cfg    = 20'h00000;
  localparam bus_addr_t reg_math_ctrl   = 20'h00010;
  localparam bus_addr_t reg_ram_ctrl    = 20'h00020;
  localparam bus_addr_t reg_math_clken  = 20'h00030; // write-only strobe
  localparam bus_addr_t reg_gpio_out    = 20'h00040;
  localparam bus_addr_t reg_gpio_oe     = 20'h00050;
  localparam bus_addr_t reg_gpio_in     = 20'h00060;
  localparam bus_addr_t reg_tcdm_data   = 20'h00080; // write launches, read gives result
  localparam bus_addr_t reg_math_result = 20'h00100;
  localparam bus_addr_t reg_id          = 20'h00800;

  localparam word_t      id_word  = 32'hCA11EF3A;
  localparam logic [7:0] ram_page = 8'h01;         // addr[19:12] of the ram window

  typedef enum logic [1:0] {
    st_idle,
    st_write,
    st_read,
    st_read_wait
  } lint_state_t;

  // math control word, msb first
  typedef struct packed {
    logic        math_reset; // bit 31
    logic [11:0] rsvd_hi;
    logic        sat;        // bit 18
    logic        clr;
    logic        rnd;
    logic        csel;
    logic        osel;       // bit 14
    logic [1:0]  mode;       // bits 13:12
    logic [4:0]  rsvd_lo;
    logic        tc;         // bit 6
    logic [5:0]  outsel;
  } math_ctrl_t;

  typedef struct packed {
    logic [18:0] rsvd_hi;
    logic        wdsel;      // bit 12
    logic [7:0]  rsvd_lo;
    width_mode_t wmode;      // bits 3:2
    width_mode_t rmode;      // bits 1:0
  } ram_ctrl_t;

  typedef struct packed {
    logic      is_ram;
    logic      is_write;
    bus_addr_t offset;
    ram_addr_t ram_addr;
    logic [1:0] byte_ofs;
    word_t     wdata;
    be_t       be;
  } access_t;

  typedef struct packed {
    tcdm_addr_t addr;
    be_t        be;
    logic       wen;         // 0 is write
    word_t      wdata;
  } tcdm_req_t;

endpackage
